/* src/cpu_types_pkg.sv */
`default_nettype none

package cpu_types_pkg;

    // Data path width.
    parameter int WORD_W = 32;

    // Data words and byte addresses share this type.
    typedef logic [WORD_W-1:0] word_t;

endpackage

`default_nettype wire

/* src/cache_types_pkg.sv */
`default_nettype none

package cache_types_pkg;
    import cpu_types_pkg::*;

    // Geometry.
    parameter int CACHE_SETS  = 16;
    parameter int BLOCK_WORDS = 2;

    parameter int IDX_W    = $clog2(CACHE_SETS);
    parameter int BLKOFF_W = $clog2(BLOCK_WORDS);
    parameter int BYTOFF_W = 2;
    parameter int TAG_W    = WORD_W - IDX_W - BLKOFF_W - BYTOFF_W;

    // Data address split, tag on top.
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [IDX_W-1:0]    idx;
        logic [BLKOFF_W-1:0] blkoff;
        logic [BYTOFF_W-1:0] bytoff;
    } dcachef_t;

    // One block with its state bits.
    typedef struct packed {
        logic                    valid;
        logic                    dirty;
        logic [TAG_W-1:0]        tag;
        word_t [BLOCK_WORDS-1:0] data;
    } dcache_frame;

    // Miss handling sequence.
    typedef enum logic [3:0] {
        DC_IDLE,
        DC_WB0,
        DC_WB1,
        DC_FETCH0,
        DC_FETCH1,
        DC_FINISH
    } dcache_state_t;

endpackage

`default_nettype wire

/* src/datapath_cache_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface datapath_cache_if;
    import cpu_types_pkg::*;

    // Request, held until dhit.
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;

    // Response.
    logic  dhit;
    word_t dmem_load;

    modport dcache (
        input  dmem_ren,
        input  dmem_wen,
        input  dmem_addr,
        input  dmem_store,
        output dhit,
        output dmem_load
    );

    modport datapath (
        output dmem_ren,
        output dmem_wen,
        output dmem_addr,
        output dmem_store,
        input  dhit,
        input  dmem_load
    );

endinterface

`default_nettype wire

/* src/caches_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface caches_if;
    import cpu_types_pkg::*;

    // Cache side request, held while dwait is high.
    logic  dren;
    logic  dwen;
    word_t daddr;
    word_t dstore;

    // Memory side answer.
    word_t dload;
    logic  dwait;

    modport dcache (
        output dren,
        output dwen,
        output daddr,
        output dstore,
        input  dload,
        input  dwait
    );

    modport memctl (
        input  dren,
        input  dwen,
        input  daddr,
        input  dstore,
        output dload,
        output dwait
    );

endinterface

`default_nettype wire

/* src/dcache.sv */
`timescale 1ns/10ps
`default_nettype none

module dcache (
    input logic              CLK,
    input logic              n_rst,
    datapath_cache_if.dcache dcif,
    caches_if.dcache         cif
);
    import cache_types_pkg::*;

    // Two ways, one LRU bit per set.
    dcache_frame frames [2][CACHE_SETS];
    logic [CACHE_SETS-1:0] lru;

    dcache_state_t state;
    dcache_state_t next_state;

    dcachef_t    req_addr;
    dcachef_t    mem_addr;
    dcache_frame hit_frame;
    dcache_frame victim;

    logic req;
    logic hit0;
    logic hit1;
    logic hit;
    logic hit_way;
    logic victim_way;
    logic xfer_done;

    assign req_addr = dcachef_t'(dcif.dmem_addr);
    assign req      = dcif.dmem_ren | dcif.dmem_wen;

    // Tag compare in both ways.
    assign hit0 = frames[0][req_addr.idx].valid &&
                  (frames[0][req_addr.idx].tag == req_addr.tag);
    assign hit1 = frames[1][req_addr.idx].valid &&
                  (frames[1][req_addr.idx].tag == req_addr.tag);
    assign hit  = hit0 | hit1;

    assign hit_way   = hit1;
    assign hit_frame = frames[hit_way][req_addr.idx];

    // The LRU bit is the way to replace next.
    // It only moves on hits, so it stays put for a whole miss.
    assign victim_way = lru[req_addr.idx];
    assign victim     = frames[victim_way][req_addr.idx];

    assign xfer_done = !cif.dwait;

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            state <= DC_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state      = state;
        dcif.dhit       = 1'b0;
        cif.dren        = 1'b0;
        cif.dwen        = 1'b0;
        mem_addr        = req_addr;
        mem_addr.blkoff = '0;
        mem_addr.bytoff = '0;

        case (state)
            DC_IDLE: begin
                if (req && hit) begin
                    dcif.dhit = 1'b1;
                end else if (req) begin
                    if (victim.valid && victim.dirty) begin
                        next_state = DC_WB0;
                    end else begin
                        next_state = DC_FETCH0;
                    end
                end
            end
            DC_WB0: begin
                // Victim block lives at its own tag.
                cif.dwen     = 1'b1;
                mem_addr.tag = victim.tag;
                if (xfer_done) begin
                    next_state = DC_WB1;
                end
            end
            DC_WB1: begin
                cif.dwen        = 1'b1;
                mem_addr.tag    = victim.tag;
                mem_addr.blkoff = 1'b1;
                if (xfer_done) begin
                    next_state = DC_FETCH0;
                end
            end
            DC_FETCH0: begin
                cif.dren = 1'b1;
                if (xfer_done) begin
                    next_state = DC_FETCH1;
                end
            end
            DC_FETCH1: begin
                cif.dren        = 1'b1;
                mem_addr.blkoff = 1'b1;
                if (xfer_done) begin
                    next_state = DC_FINISH;
                end
            end
            DC_FINISH: begin
                next_state = DC_IDLE;
            end
            default: begin
                next_state = DC_IDLE;
            end
        endcase
    end

    assign cif.daddr  = mem_addr;
    assign cif.dstore = victim.data[mem_addr.blkoff];

    assign dcif.dmem_load = hit_frame.data[req_addr.blkoff];

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < CACHE_SETS; s++) begin
                    frames[w][s] <= '0;
                end
            end
            lru <= '0;
        end else begin
            case (state)
                DC_IDLE: begin
                    // Point LRU away from the way just used.
                    if (req && hit) begin
                        lru[req_addr.idx] <= ~hit_way;
                    end
                    if (dcif.dmem_wen && hit) begin
                        frames[hit_way][req_addr.idx].dirty <= 1'b1;
                        frames[hit_way][req_addr.idx].data[req_addr.blkoff] <=
                            dcif.dmem_store;
                    end
                end
                DC_FETCH0: begin
                    // Old contents are gone once the first word lands.
                    if (xfer_done) begin
                        frames[victim_way][req_addr.idx].valid   <= 1'b0;
                        frames[victim_way][req_addr.idx].data[0] <= cif.dload;
                    end
                end
                DC_FETCH1: begin
                    if (xfer_done) begin
                        frames[victim_way][req_addr.idx].data[1] <= cif.dload;
                    end
                end
                DC_FINISH: begin
                    frames[victim_way][req_addr.idx].valid <= 1'b1;
                    frames[victim_way][req_addr.idx].dirty <= 1'b0;
                    frames[victim_way][req_addr.idx].tag   <= req_addr.tag;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/memory_control.sv */
`timescale 1ns/10ps
`default_nettype none

module memory_control (
    input  logic                 CLK,
    input  logic                 n_rst,
    caches_if.memctl             cif,
    output logic                 ram_ren,
    output logic                 ram_wen,
    output cpu_types_pkg::word_t ram_addr,
    output cpu_types_pkg::word_t ram_store,
    input  cpu_types_pkg::word_t ram_load,
    input  logic                 ram_ready
);
    import cpu_types_pkg::*;

    typedef enum logic [1:0] {
        MC_IDLE,
        MC_BUSY,
        MC_DONE
    } mc_state_t;

    mc_state_t state;
    word_t     load_q;

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            state   <= MC_IDLE;
            ram_ren <= 1'b0;
            ram_wen <= 1'b0;
        end else begin
            case (state)
                MC_IDLE: begin
                    if (cif.dren || cif.dwen) begin
                        state   <= MC_BUSY;
                        ram_ren <= cif.dren;
                        ram_wen <= cif.dwen;
                    end
                end
                MC_BUSY: begin
                    // Drop the request so the RAM sees it once.
                    if (ram_ready) begin
                        state   <= MC_DONE;
                        ram_ren <= 1'b0;
                        ram_wen <= 1'b0;
                    end
                end
                MC_DONE: begin
                    state <= MC_IDLE;
                end
                default: begin
                    state <= MC_IDLE;
                end
            endcase
        end
    end

    // Address and store word follow the cache until the request starts.
    always_ff @(posedge CLK) begin
        if (state == MC_IDLE) begin
            ram_addr  <= cif.daddr;
            ram_store <= cif.dstore;
        end
        if ((state == MC_BUSY) && ram_ready) begin
            load_q <= ram_load;
        end
    end

    // One cycle of dwait low per transfer.
    assign cif.dwait = (state != MC_DONE);
    assign cif.dload = load_q;

endmodule

`default_nettype wire

/* src/cache_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_subsystem (
    input  logic                 CLK,
    input  logic                 n_rst,
    input  logic                 dmem_ren,
    input  logic                 dmem_wen,
    input  cpu_types_pkg::word_t dmem_addr,
    input  cpu_types_pkg::word_t dmem_store,
    output logic                 dhit,
    output cpu_types_pkg::word_t dmem_load,
    output logic                 ram_ren,
    output logic                 ram_wen,
    output cpu_types_pkg::word_t ram_addr,
    output cpu_types_pkg::word_t ram_store,
    input  cpu_types_pkg::word_t ram_load,
    input  logic                 ram_ready
);

    datapath_cache_if dcif ();
    caches_if         cif ();

    // Datapath port onto the cache interface.
    assign dcif.dmem_ren   = dmem_ren;
    assign dcif.dmem_wen   = dmem_wen;
    assign dcif.dmem_addr  = dmem_addr;
    assign dcif.dmem_store = dmem_store;
    assign dhit            = dcif.dhit;
    assign dmem_load       = dcif.dmem_load;

    dcache u_dcache (
        .CLK   (CLK),
        .n_rst (n_rst),
        .dcif  (dcif),
        .cif   (cif)
    );

    memory_control u_memory_control (
        .CLK       (CLK),
        .n_rst     (n_rst),
        .cif       (cif),
        .ram_ren   (ram_ren),
        .ram_wen   (ram_wen),
        .ram_addr  (ram_addr),
        .ram_store (ram_store),
        .ram_load  (ram_load),
        .ram_ready (ram_ready)
    );

endmodule

`default_nettype wire

/* testbench/cache_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_assertions (
    input logic                           CLK,
    input logic                           n_rst,
    input logic                           dmem_ren,
    input logic                           dmem_wen,
    input logic                           dhit,
    input logic                           dren,
    input logic                           dwen,
    input logic                           dwait,
    input cache_types_pkg::dcache_state_t dstate,
    input logic                           ram_ren,
    input logic                           ram_wen,
    input cpu_types_pkg::word_t           ram_addr,
    input cpu_types_pkg::word_t           ram_store,
    input logic                           ram_ready
);
    import cache_types_pkg::*;

    int n_dir = 0;
    int n_stable = 0;
    int n_hit = 0;
    int n_reset = 0;
    int n_fill = 0;
    int fail_count;

    assign fail_count = n_dir + n_stable + n_hit + n_reset + n_fill;

    // One direction at a time on every request port.
    assert property (@(posedge CLK) disable iff (!n_rst)
        !(dmem_ren && dmem_wen) && !(dren && dwen) && !(ram_ren && ram_wen))
    else begin
        $error("read and write requested together");
        n_dir++;
    end

    assert property (@(posedge CLK) disable iff (!n_rst)
        (ram_ren || ram_wen) && !ram_ready |=> $stable(ram_ren) && $stable(ram_wen) &&
            $stable(ram_addr) && $stable(ram_store))
    else begin
        $error("RAM request changed before ram_ready");
        n_stable++;
    end

    assert property (@(posedge CLK) disable iff (!n_rst) dhit |-> (dmem_ren || dmem_wen))
    else begin
        $error("dhit without a request");
        n_hit++;
    end

    // Quiet memory side in and right after reset.
    assert property (@(posedge CLK) (!n_rst || $rose(n_rst)) |->
        !dren && !dwen && !ram_ren && !ram_wen && dwait && !dhit)
    else begin
        $error("memory requests active around reset");
        n_reset++;
    end

    // A freshly filled block answers the held request.
    assert property (@(posedge CLK) disable iff (!n_rst)
        (dstate == DC_FINISH) |=> dhit)
    else begin
        $error("no dhit after a block fill");
        n_fill++;
    end

endmodule

`default_nettype wire

/* testbench/tb_cache_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cache_subsystem;
    import cpu_types_pkg::*;

    localparam word_t FILL    = 32'h5a5a0000;
    localparam int    TIMEOUT = 200;

    logic  CLK;
    logic  n_rst;
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;
    logic  dhit;
    word_t dmem_load;
    logic  ram_ren;
    logic  ram_wen;
    word_t ram_addr;
    word_t ram_store;
    word_t ram_load = '0;
    logic  ram_ready = 1'b0;

    word_t ram_mem [word_t];
    word_t ref_mem [word_t];
    word_t wb_addr_q [$];
    word_t wb_data_q [$];
    int    seed = 32'hd1997f0f;
    int    delay = 0;
    bit    pending = 1'b0;
    int    ram_reads = 0;
    int    errors = 0;
    int    test_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    bit    timed_out = 1'b0;
    word_t rdata;

    cache_subsystem u_dut (
        .CLK        (CLK),
        .n_rst      (n_rst),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .dhit       (dhit),
        .dmem_load  (dmem_load),
        .ram_ren    (ram_ren),
        .ram_wen    (ram_wen),
        .ram_addr   (ram_addr),
        .ram_store  (ram_store),
        .ram_load   (ram_load),
        .ram_ready  (ram_ready)
    );

    bind cache_subsystem cache_assertions u_cache_assertions (
        .CLK       (CLK),
        .n_rst     (n_rst),
        .dmem_ren  (dmem_ren),
        .dmem_wen  (dmem_wen),
        .dhit      (dhit),
        .dren      (cif.dren),
        .dwen      (cif.dwen),
        .dwait     (cif.dwait),
        .dstate    (u_dcache.state),
        .ram_ren   (ram_ren),
        .ram_wen   (ram_wen),
        .ram_addr  (ram_addr),
        .ram_store (ram_store),
        .ram_ready (ram_ready)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #4 CLK = ~CLK;
        end
    end

    function automatic word_t expected_word(word_t addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return addr ^ FILL;
    endfunction

    // RAM answers 0 to 3 cycles after it sees a request.
    always @(posedge CLK) begin
        if (!n_rst || ram_ready) begin
            ram_ready <= 1'b0;
            pending = 1'b0;
        end else if (ram_ren || ram_wen) begin
            if (!pending) begin
                pending = 1'b1;
                delay = $unsigned($random(seed)) % 4;
            end
            if (delay == 0) begin
                pending = 1'b0;
                ram_ready <= 1'b1;
                if (ram_wen) begin
                    ram_mem[ram_addr] = ram_store;
                    wb_addr_q.push_back(ram_addr);
                    wb_data_q.push_back(ram_store);
                end else begin
                    ram_reads++;
                    ram_load <= ram_mem.exists(ram_addr) ? ram_mem[ram_addr] :
                                                           (ram_addr ^ FILL);
                end
            end else begin
                delay--;
            end
        end
    end

    function automatic int total_errors();
        return errors + u_dut.u_cache_assertions.fail_count;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (!timed_out && exp !== act) begin
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic access(input logic wr, input word_t addr, input word_t data);
        int cycles;
        cycles = 0;
        @(posedge CLK);
        dmem_ren   <= !wr;
        dmem_wen   <= wr;
        dmem_addr  <= addr;
        dmem_store <= data;
        @(negedge CLK);
        while (!dhit && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (!dhit) begin
            $display("timeout: no dhit for address %h within %0d cycles", addr, TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end
        rdata = dmem_load;
        @(posedge CLK);
        dmem_ren <= 1'b0;
        dmem_wen <= 1'b0;
        if (wr) begin
            ref_mem[addr] = data;
        end
    endtask

    task automatic read_check(input word_t addr);
        access(1'b0, addr, '0);
        check_word("dmem_load", expected_word(addr), rdata);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() == test_errors) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end
        test_errors = total_errors();
    endtask

    task automatic finish_run();
        $display("tests %0d, failed %0d, value errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, u_dut.u_cache_assertions.fail_count);
        if (total_errors() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    initial begin
        wait (timed_out);
        finish_run();
    end

    initial begin
        int         base_reads;
        int         wb_start;
        logic [5:0] w;
        logic       wr;
        word_t      addr;
        n_rst      = 1'b0;
        dmem_ren   = 1'b0;
        dmem_wen   = 1'b0;
        dmem_addr  = '0;
        dmem_store = '0;
        repeat (4) @(posedge CLK);
        n_rst <= 1'b1;

        repeat (4) begin
            @(negedge CLK);
            check_word("dhit", '0, word_t'(dhit));
            check_word("ram_ren", '0, word_t'(ram_ren));
            check_word("ram_wen", '0, word_t'(ram_wen));
        end
        read_check(32'h0000_0100);
        base_reads = ram_reads;
        read_check(32'h0000_0100);
        check_word("ram_ren count", base_reads, ram_reads);
        end_test("reset and first read");

        base_reads = ram_reads;
        wb_start   = wb_addr_q.size();
        access(1'b1, 32'h0000_0104, 32'hcafe_0001);
        read_check(32'h0000_0104);
        check_word("ram_ren count", base_reads, ram_reads);
        check_word("ram_wen count", wb_start, wb_addr_q.size());
        access(1'b1, 32'h0000_0208, 32'hcafe_0002);
        read_check(32'h0000_0208);
        read_check(32'h0000_020c);
        end_test("write hit and write miss");

        // Set 2 with tags 0, 1 and 2.
        access(1'b1, 32'h0000_0010, 32'h1111_aaaa);
        access(1'b1, 32'h0000_0014, 32'h2222_bbbb);
        read_check(32'h0000_0090);
        wb_start = wb_addr_q.size();
        read_check(32'h0000_0110);
        check_word("ram_wen count", wb_start + 2, wb_addr_q.size());
        if (wb_addr_q.size() == wb_start + 2) begin
            check_word("ram_addr", 32'h0000_0010, wb_addr_q[wb_start]);
            check_word("ram_store", 32'h1111_aaaa, wb_data_q[wb_start]);
            check_word("ram_addr", 32'h0000_0014, wb_addr_q[wb_start+1]);
            check_word("ram_store", 32'h2222_bbbb, wb_data_q[wb_start+1]);
        end
        read_check(32'h0000_0010);
        read_check(32'h0000_0014);
        end_test("dirty eviction");

        read_check(32'h0000_0018);
        read_check(32'h0000_0098);
        read_check(32'h0000_0018);
        read_check(32'h0000_0118);
        base_reads = ram_reads;
        read_check(32'h0000_0018);
        check_word("ram_ren count", base_reads, ram_reads);
        read_check(32'h0000_0098);
        check_word("ram_ren count", base_reads + 2, ram_reads);
        end_test("lru replacement");

        // 64 words as 8 tags over 4 sets.
        repeat (200) begin
            w    = 6'($random(seed));
            wr   = 1'($random(seed));
            addr = {22'b0, w[5:3], 2'b00, w[2:1], w[0], 2'b00};
            if (wr) begin
                access(1'b1, addr, $random(seed));
            end else begin
                read_check(addr);
            end
        end
        end_test("random traffic");

        finish_run();
    end

endmodule

`default_nettype wire

/* tb.f */
src/cpu_types_pkg.sv
src/cache_types_pkg.sv
src/datapath_cache_if.sv
src/caches_if.sv
src/dcache.sv
src/memory_control.sv
src/cache_subsystem.sv
testbench/cache_assertions.sv
testbench/tb_cache_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cache subsystem testbench with Verilator.
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_cache_subsystem -f tb.f -o sim_tb

./obj_dir/sim_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
